//--- sources.f
control_pkg.sv
condition_check.sv
data_decoder.sv
branch_decoder.sv
control_unit.sv
control_unit_sva.sv
tb_control_unit.sv

//--- Makefile
# Verilator build and run of the control unit testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_control_unit -o sim_control_unit
	./obj_dir/sim_control_unit +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@grep -q "^STATUS: PASS$$" sim.log && echo "Result: passed" || \
		(echo "Result: failed"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit;

    localparam int data_width    = 64;
    localparam int timeout_limit = 20;

    // Fetch reads the instruction at the PC and steps the PC
    localparam control_pkg::control_word_t fetch_word =
        (31'd1 << control_pkg::instr_load_bit) |
        (31'd1 << control_pkg::mem_read_bit) |
        (31'(control_pkg::pc_increment) << control_pkg::pc_sel_lsb);

    logic                       clock;
    logic                       reset;
    control_pkg::instruction_t  instruction;
    control_pkg::status_t       status;
    control_pkg::control_word_t control_word;
    logic [data_width-1:0]      constant;

    string test_name;
    logic  test_failed;
    logic  timed_out;
    int    failures_at_start;
    int    tests_run;
    int    tests_failed;

    control_unit #(
        .data_width (data_width)
    ) dut_i (
        .clock        (clock),
        .reset        (reset),
        .instruction  (instruction),
        .status       (status),
        .control_word (control_word),
        .constant     (constant)
    );

    always #50 clock = ~clock;

    task automatic start_test(string name);
        test_name         = name;
        test_failed       = 1'b0;
        failures_at_start = dut_i.sva_i.failure_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_failed || timed_out || dut_i.sva_i.failure_count != failures_at_start) begin
            tests_failed++;
            $display("test %s: failed", test_name);
        end else begin
            $display("test %s: passed", test_name);
        end
    endtask

    // Counts falling edges until the fetch word shows again
    task automatic wait_for_fetch(output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (control_word != fetch_word && cycles < timeout_limit);
        if (control_word != fetch_word) begin
            timed_out = 1'b1;
            $display("Timeout in test %s: no fetch word within %0d cycles",
                     test_name, timeout_limit);
        end
    endtask

    task automatic check_cycles(int expected, int actual);
        if (!timed_out && expected != actual) begin
            test_failed = 1'b1;
            $display("CHECK FAILED: test %s, cycles to fetch, expected %0d, actual %0d",
                     test_name, expected, actual);
        end
    endtask

    // Drive on the edge that leaves fetch, hold until fetch returns
    task automatic issue(control_pkg::instruction_t instr, int expected_cycles);
        int cycles;
        if (!timed_out) begin
            @(posedge clock);
            instruction <= instr;
            status      <= control_pkg::status_t'($urandom());
            wait_for_fetch(cycles);
            check_cycles(expected_cycles, cycles);
        end
    endtask

    // Opcode bits fixed at the top, everything below random
    task automatic run_test(string name, control_pkg::instruction_t op_bits, int op_width,
                            int count, int cycles);
        control_pkg::instruction_t keep;
        int n;
        keep = 32'hffff_ffff >> op_width;
        start_test(name);
        for (n = 0; n < count; n++) begin
            issue((control_pkg::instruction_t'($urandom()) & keep) | op_bits, cycles);
        end
        finish_test();
    endtask

    initial begin
        int cycles;
        clock        = 1'b0;
        reset        = 1'b1;
        instruction  = '0;
        status       = '0;
        timed_out    = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(3075));

        start_test("reset");
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        wait_for_fetch(cycles);
        check_cycles(1, cycles);
        finish_test();

        // Load and store
        run_test("ldur", {control_pkg::op_ldur, 21'd0}, 11, 8, 2);
        run_test("stur", {control_pkg::op_stur, 21'd0}, 11, 8, 2);

        // Immediate and move-wide
        run_test("addi", {control_pkg::op_addi, 22'd0}, 10, 4, 2);
        run_test("subi", {control_pkg::op_subi, 22'd0}, 10, 4, 2);
        run_test("andi", {control_pkg::op_andi, 22'd0}, 10, 4, 2);
        run_test("orri", {control_pkg::op_orri, 22'd0}, 10, 4, 2);
        run_test("eori", {control_pkg::op_eori, 22'd0}, 10, 4, 2);
        run_test("movz", {control_pkg::op_movz, 23'd0}, 9, 8, 2);

        // Register formats
        run_test("add", {control_pkg::op_add, 21'd0}, 11, 4, 2);
        run_test("sub", {control_pkg::op_sub, 21'd0}, 11, 4, 2);
        run_test("and", {control_pkg::op_and, 21'd0}, 11, 4, 2);
        run_test("orr", {control_pkg::op_orr, 21'd0}, 11, 4, 2);
        run_test("eor", {control_pkg::op_eor, 21'd0}, 11, 4, 2);
        run_test("lsl", {control_pkg::op_lsl, 21'd0}, 11, 4, 2);
        run_test("lsr", {control_pkg::op_lsr, 21'd0}, 11, 4, 2);

        // Branches, BL takes an extra cycle
        run_test("b", {control_pkg::op_b, 26'd0}, 6, 4, 2);
        run_test("b_cond", {control_pkg::op_bcond, 24'd0}, 8, 32, 2);
        run_test("cbz", {control_pkg::op_cbz, 24'd0}, 8, 8, 2);
        run_test("cbnz", {control_pkg::op_cbnz, 24'd0}, 8, 8, 2);
        run_test("bl", {control_pkg::op_bl, 26'd0}, 6, 6, 3);
        run_test("br", {control_pkg::op_br, 21'd0}, 11, 4, 2);

        // Unknown opcodes on the data side and the branch side
        run_test("unknown_data", 32'h0000_0000, 11, 4, 2);
        run_test("unknown_branch", 32'hf400_0000, 8, 4, 2);

        // One more edge so the last return to fetch is checked
        @(posedge clock);
        @(negedge clock);

        $display("tests run %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_failed, dut_i.sva_i.failure_count);
        if (tests_failed == 0 && !timed_out && dut_i.sva_i.failure_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- control_unit_sva.sv
`timescale 1ns/1ps

module control_unit_sva #(
    parameter int data_width = 64
) (
    input logic                       clock,
    input logic                       reset,
    input control_pkg::instruction_t  instruction,
    input control_pkg::status_t       status,
    input control_pkg::state_t        state,
    input control_pkg::control_word_t control_word,
    input logic [data_width-1:0]      constant
);

    // Assertion failures so far, read by the testbench
    int failure_count = 0;

    // instr_load, mem_read and PC increment, memory addressed by the PC
    localparam control_pkg::control_word_t fetch_word =
        {20'd0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0, 2'd1, 1'b1, 1'b0};

    logic fetch_like;
    logic is_bl;
    logic final_cycle;

    function automatic control_pkg::control_word_t word(
        logic [4:0] da,
        logic [4:0] sa,
        logic [4:0] sb,
        logic [4:0] fs,
        logic       mem_write,
        logic       reg_write,
        logic       b_sel,
        logic [1:0] c_sel,
        logic [1:0] pc_sel,
        logic       mem_read,
        logic       address_source
    );
        // instr_load and status_load stay low outside fetch
        return {da, sa, sb, fs, mem_write, reg_write, 1'b0, 1'b0, b_sel, c_sel, pc_sel,
                mem_read, address_source};
    endfunction

    // ARM pairs: even code tests, odd code inverts, NV still branches
    function automatic logic condition_holds(logic [3:0] code, logic [3:0] nzcv);
        logic n;
        logic z;
        logic c;
        logic v;
        logic base;
        {n, z, c, v} = nzcv;
        case (code[3:1])
            3'd0:    base = z;
            3'd1:    base = c;
            3'd2:    base = n;
            3'd3:    base = v;
            3'd4:    base = c && !z;
            3'd5:    base = (n == v);
            3'd6:    base = !z && (n == v);
            default: base = 1'b1;
        endcase
        return (code[0] && code != 4'hf) ? !base : base;
    endfunction

    function automatic control_pkg::alu_fn_t opcode_function(control_pkg::instruction_t i);
        if (i[31:22] == control_pkg::op_addi || i[31:21] == control_pkg::op_add)
            return control_pkg::fn_add;
        if (i[31:22] == control_pkg::op_subi || i[31:21] == control_pkg::op_sub)
            return control_pkg::fn_sub;
        if (i[31:22] == control_pkg::op_andi || i[31:21] == control_pkg::op_and)
            return control_pkg::fn_and;
        if (i[31:22] == control_pkg::op_orri || i[31:21] == control_pkg::op_orr)
            return control_pkg::fn_orr;
        if (i[31:22] == control_pkg::op_eori || i[31:21] == control_pkg::op_eor)
            return control_pkg::fn_eor;
        if (i[31:21] == control_pkg::op_lsl)
            return control_pkg::fn_lsl;
        if (i[31:21] == control_pkg::op_lsr)
            return control_pkg::fn_lsr;
        return control_pkg::fn_pass_b;
    endfunction

    function automatic control_pkg::control_word_t expected_word(
        control_pkg::instruction_t i,
        control_pkg::status_t      s,
        control_pkg::state_t       st
    );
        logic [4:0] rd;
        logic [4:0] rn;
        logic [1:0] taken;
        logic [1:0] rel;
        rd  = i[4:0];
        rn  = i[9:5];
        rel = control_pkg::pc_relative;
        if (st == control_pkg::st_execute_2) begin
            if (i[31:26] != control_pkg::op_bl)
                return '0;
            return word(5'd0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 2'd0, rel, 1'b0, 1'b0);
        end
        if (i[31:21] == control_pkg::op_ldur)
            return word(rd, rn, 5'd0, control_pkg::fn_add, 1'b0, 1'b1, 1'b1,
                        control_pkg::src_memory, 2'd0, 1'b1, 1'b1);
        if (i[31:21] == control_pkg::op_stur)
            return word(5'd0, rn, rd, control_pkg::fn_add, 1'b1, 1'b0, 1'b1,
                        2'd0, 2'd0, 1'b0, 1'b1);
        if (i[31:22] inside {control_pkg::op_addi, control_pkg::op_subi, control_pkg::op_andi,
                             control_pkg::op_orri, control_pkg::op_eori})
            return word(rd, rn, 5'd0, opcode_function(i), 1'b0, 1'b1, 1'b1,
                        control_pkg::src_alu, 2'd0, 1'b0, 1'b0);
        if (i[31:23] == control_pkg::op_movz)
            return word(rd, rn, 5'd0, control_pkg::fn_pass_b, 1'b0, 1'b1, 1'b1,
                        control_pkg::src_alu, 2'd0, 1'b0, 1'b0);
        if (i[31:21] inside {control_pkg::op_add, control_pkg::op_sub, control_pkg::op_and,
                             control_pkg::op_orr, control_pkg::op_eor})
            return word(rd, rn, i[20:16], opcode_function(i), 1'b0, 1'b1, 1'b0,
                        control_pkg::src_alu, 2'd0, 1'b0, 1'b0);
        // Shifts take the amount as the constant
        if (i[31:21] inside {control_pkg::op_lsl, control_pkg::op_lsr})
            return word(rd, rn, i[20:16], opcode_function(i), 1'b0, 1'b1, 1'b1,
                        control_pkg::src_alu, 2'd0, 1'b0, 1'b0);
        if (i[31:26] == control_pkg::op_b)
            return word(5'd0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 2'd0, rel, 1'b0, 1'b0);
        if (i[31:26] == control_pkg::op_bl)
            return word(5'd30, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 1'b0,
                        control_pkg::src_pc, 2'd0, 1'b0, 1'b0);
        if (i[31:24] == control_pkg::op_bcond) begin
            taken = condition_holds(i[3:0], s[3:0]) ? rel : control_pkg::pc_hold;
            return word(5'd0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 2'd0, taken, 1'b0, 1'b0);
        end
        if (i[31:24] inside {control_pkg::op_cbz, control_pkg::op_cbnz}) begin
            // Zero flag of the passed Rt against the CBZ or CBNZ sense
            taken = (s[4] == (i[31:24] == control_pkg::op_cbz)) ? rel : control_pkg::pc_hold;
            return word(5'd0, 5'd0, rd, control_pkg::fn_pass_b, 1'b0, 1'b0, 1'b0,
                        2'd0, taken, 1'b0, 1'b0);
        end
        if (i[31:21] == control_pkg::op_br)
            return word(5'd0, rn, 5'd0, control_pkg::fn_pass_b, 1'b0, 1'b0, 1'b0,
                        2'd0, control_pkg::pc_register, 1'b0, 1'b0);
        return '0;
    endfunction

    function automatic logic [data_width-1:0] expected_constant(
        control_pkg::instruction_t i,
        control_pkg::state_t       st
    );
        logic [data_width-1:0] offset_26;
        logic [data_width-1:0] offset_19;
        offset_26 = data_width'($signed(i[25:0]));
        offset_19 = data_width'($signed(i[23:5]));
        if (st == control_pkg::st_execute_2)
            return (i[31:26] == control_pkg::op_bl) ? offset_26 : '0;
        if (i[31:21] inside {control_pkg::op_ldur, control_pkg::op_stur})
            return data_width'($signed(i[20:12]));
        if (i[31:22] inside {control_pkg::op_addi, control_pkg::op_subi, control_pkg::op_andi,
                             control_pkg::op_orri, control_pkg::op_eori})
            return data_width'(i[21:10]);
        if (i[31:23] == control_pkg::op_movz)
            return data_width'(i[20:5]) << (16 * i[22:21]);
        if (i[31:21] inside {control_pkg::op_lsl, control_pkg::op_lsr})
            return data_width'(i[15:10]);
        if (i[31:26] inside {control_pkg::op_b, control_pkg::op_bl})
            return offset_26;
        if (i[31:24] inside {control_pkg::op_bcond, control_pkg::op_cbz, control_pkg::op_cbnz})
            return offset_19;
        return '0;
    endfunction

    // Unused state encoding counts as fetch
    assign fetch_like  = (state != control_pkg::st_execute) && (state != control_pkg::st_execute_2);
    assign is_bl       = (instruction[31:26] == control_pkg::op_bl);
    assign final_cycle = (state == control_pkg::st_execute && !is_bl) ||
                         (state == control_pkg::st_execute_2);

    reset_word_check: assert property (@(posedge clock) reset |-> control_word == fetch_word)
    else begin
        failure_count++;
        $error("control word %h during reset is not the fetch word", control_word);
    end

    fetch_word_check: assert property (@(posedge clock) disable iff (reset)
        fetch_like |-> (control_word == fetch_word && constant == '0))
    else begin
        failure_count++;
        $error("fetch cycle gave word %h and constant %h", control_word, constant);
    end

    execute_word_check: assert property (@(posedge clock) disable iff (reset)
        !fetch_like |-> control_word == expected_word(instruction, status, state))
    else begin
        failure_count++;
        $error("instruction %h gave word %h, expected %h", instruction, control_word,
               expected_word(instruction, status, state));
    end

    constant_check: assert property (@(posedge clock) disable iff (reset)
        !fetch_like |-> constant == expected_constant(instruction, state))
    else begin
        failure_count++;
        $error("instruction %h gave constant %h, expected %h", instruction, constant,
               expected_constant(instruction, state));
    end

    return_to_fetch_check: assert property (@(posedge clock) disable iff (reset)
        final_cycle |=> control_word == fetch_word)
    else begin
        failure_count++;
        $error("fetch word did not follow the last execute cycle");
    end

    // BL links first, then branches
    bl_sequence_check: assert property (@(posedge clock) disable iff (reset)
        (state == control_pkg::st_execute && is_bl) |=> state == control_pkg::st_execute_2)
    else begin
        failure_count++;
        $error("BL did not move on to the second execute cycle");
    end

endmodule

bind control_unit control_unit_sva #(
    .data_width (data_width)
) sva_i (
    .clock        (clock),
    .reset        (reset),
    .instruction  (instruction),
    .status       (status),
    .state        (state),
    .control_word (control_word),
    .constant     (constant)
);

//--- control_unit.sv
`timescale 1ns/1ps

module control_unit #(
    parameter int data_width = 64
) (
    input  logic                       clock,
    input  logic                       reset,
    input  control_pkg::instruction_t  instruction,
    input  control_pkg::status_t       status,
    output control_pkg::control_word_t control_word,
    output logic [data_width-1:0]      constant
);

    control_pkg::state_t        state;
    control_pkg::state_t        next_state;
    control_pkg::control_word_t fetch_word;
    logic                       branch_select;

    control_pkg::control_word_t data_control_word;
    control_pkg::state_t        data_next_state;
    logic [data_width-1:0]      data_constant;

    control_pkg::control_word_t branch_control_word;
    control_pkg::state_t        branch_next_state;
    logic [data_width-1:0]      branch_constant;

    data_decoder #(
        .data_width (data_width)
    ) data_decoder_i (
        .instruction  (instruction),
        .state        (state),
        .control_word (data_control_word),
        .next_state   (data_next_state),
        .constant     (data_constant)
    );

    branch_decoder #(
        .data_width (data_width)
    ) branch_decoder_i (
        .instruction  (instruction),
        .state        (state),
        .status       (status),
        .control_word (branch_control_word),
        .next_state   (branch_next_state),
        .constant     (branch_constant)
    );

    // Instruction fetch from the PC with increment, memory addressed by the PC
    always_comb begin
        fetch_word = '0;
        fetch_word[control_pkg::instr_load_bit]  = 1'b1;
        fetch_word[control_pkg::mem_read_bit]    = 1'b1;
        fetch_word[control_pkg::pc_sel_lsb +: 2] = control_pkg::pc_increment;
    end

    // All branch formats share 101 in bits 28 to 26
    assign branch_select = (instruction[28:26] == 3'b101);

    always_comb begin
        case (state)
            control_pkg::st_execute, control_pkg::st_execute_2: begin
                control_word = branch_select ? branch_control_word : data_control_word;
                next_state   = branch_select ? branch_next_state : data_next_state;
                constant     = branch_select ? branch_constant : data_constant;
            end
            // Unused encoding falls back to fetch
            default: begin
                control_word = fetch_word;
                next_state   = control_pkg::st_execute;
                constant     = '0;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= control_pkg::st_fetch;
        end else begin
            state <= next_state;
        end
    end

endmodule

//--- branch_decoder.sv
`timescale 1ns/1ps

module branch_decoder #(
    parameter int data_width = 64
) (
    input  control_pkg::instruction_t  instruction,
    input  control_pkg::state_t        state,
    input  control_pkg::status_t       status,
    output control_pkg::control_word_t control_word,
    output control_pkg::state_t        next_state,
    output logic [data_width-1:0]      constant
);

    logic [5:0]  op6;
    logic [7:0]  op8;
    logic [10:0] op11;

    control_pkg::reg_addr_t rt;
    control_pkg::reg_addr_t rn;

    logic                  cond_taken;
    logic                  cb_taken;
    logic [data_width-1:0] imm26_constant;
    logic [data_width-1:0] imm19_constant;

    assign op6  = instruction[31:26];
    assign op8  = instruction[31:24];
    assign op11 = instruction[31:21];

    assign rt = instruction[4:0];
    assign rn = instruction[9:5];

    // Word offsets, sign-extended
    assign imm26_constant = {{(data_width-26){instruction[25]}}, instruction[25:0]};
    assign imm19_constant = {{(data_width-19){instruction[23]}}, instruction[23:5]};

    condition_check condition_check_i (
        .condition (instruction[3:0]),
        .flags     (status[3:0]),
        .taken     (cond_taken)
    );

    // CBZ branches on zero, CBNZ on nonzero
    assign cb_taken = (op8 == control_pkg::op_cbz) ? status[4] : !status[4];

    always_comb begin
        control_word = '0;
        next_state   = control_pkg::st_fetch;
        constant     = '0;
        if (state == control_pkg::st_execute) begin
            if (op6 == control_pkg::op_b) begin
                control_word[control_pkg::pc_sel_lsb +: 2] = control_pkg::pc_relative;
                constant = imm26_constant;
            end else if (op6 == control_pkg::op_bl) begin
                // Link first, branch in the second cycle
                control_word[control_pkg::da_lsb +: 5]    = 5'd30;
                control_word[control_pkg::c_sel_lsb +: 2] = control_pkg::src_pc;
                control_word[control_pkg::reg_write_bit]  = 1'b1;
                next_state = control_pkg::st_execute_2;
                constant   = imm26_constant;
            end else if (op8 == control_pkg::op_bcond) begin
                control_word[control_pkg::pc_sel_lsb +: 2] =
                    cond_taken ? control_pkg::pc_relative : control_pkg::pc_hold;
                constant = imm19_constant;
            end else if (op8 == control_pkg::op_cbz || op8 == control_pkg::op_cbnz) begin
                // Rt passes through the ALU to raise the zero flag
                control_word[control_pkg::sb_lsb +: 5] = rt;
                control_word[control_pkg::fs_lsb +: 5] = control_pkg::fn_pass_b;
                control_word[control_pkg::pc_sel_lsb +: 2] =
                    cb_taken ? control_pkg::pc_relative : control_pkg::pc_hold;
                constant = imm19_constant;
            end else if (op11 == control_pkg::op_br) begin
                control_word[control_pkg::sa_lsb +: 5]     = rn;
                control_word[control_pkg::fs_lsb +: 5]     = control_pkg::fn_pass_b;
                control_word[control_pkg::pc_sel_lsb +: 2] = control_pkg::pc_register;
            end
        end else if (state == control_pkg::st_execute_2) begin
            // Only BL reaches the second execute cycle
            if (op6 == control_pkg::op_bl) begin
                control_word[control_pkg::pc_sel_lsb +: 2] = control_pkg::pc_relative;
                constant = imm26_constant;
            end
        end
    end

endmodule

//--- data_decoder.sv
`timescale 1ns/1ps

module data_decoder #(
    parameter int data_width = 64
) (
    input  control_pkg::instruction_t  instruction,
    input  control_pkg::state_t        state,
    output control_pkg::control_word_t control_word,
    output control_pkg::state_t        next_state,
    output logic [data_width-1:0]      constant
);

    logic [10:0] op11;
    logic [9:0]  op10;
    logic [8:0]  op9;

    control_pkg::reg_addr_t rd;
    control_pkg::reg_addr_t rn;
    control_pkg::reg_addr_t rm;

    logic [data_width-1:0] d_constant;
    logic [data_width-1:0] i_constant;
    logic [data_width-1:0] movz_field;
    logic [data_width-1:0] movz_constant;
    logic [data_width-1:0] shift_constant;

    logic                  i_valid;
    control_pkg::alu_fn_t  i_fn;
    logic                  r_valid;
    logic                  r_shift;
    control_pkg::alu_fn_t  r_fn;

    assign op11 = instruction[31:21];
    assign op10 = instruction[31:22];
    assign op9  = instruction[31:23];

    // Rt shares the Rd position
    assign rd = instruction[4:0];
    assign rn = instruction[9:5];
    assign rm = instruction[20:16];

    assign d_constant     = {{(data_width-9){instruction[20]}}, instruction[20:12]};
    assign i_constant     = {{(data_width-12){1'b0}}, instruction[21:10]};
    assign movz_field     = {{(data_width-16){1'b0}}, instruction[20:5]};
    // hw field picks a 16-bit lane
    assign movz_constant  = movz_field << {instruction[22:21], 4'b0000};
    assign shift_constant = {{(data_width-6){1'b0}}, instruction[15:10]};

    // I format ALU function
    always_comb begin
        i_valid = 1'b1;
        case (op10)
            control_pkg::op_addi: i_fn = control_pkg::fn_add;
            control_pkg::op_subi: i_fn = control_pkg::fn_sub;
            control_pkg::op_andi: i_fn = control_pkg::fn_and;
            control_pkg::op_orri: i_fn = control_pkg::fn_orr;
            control_pkg::op_eori: i_fn = control_pkg::fn_eor;
            default: begin
                i_valid = 1'b0;
                i_fn    = control_pkg::fn_add;
            end
        endcase
    end

    // R format ALU function
    always_comb begin
        r_valid = 1'b1;
        r_shift = 1'b0;
        case (op11)
            control_pkg::op_add: r_fn = control_pkg::fn_add;
            control_pkg::op_sub: r_fn = control_pkg::fn_sub;
            control_pkg::op_and: r_fn = control_pkg::fn_and;
            control_pkg::op_orr: r_fn = control_pkg::fn_orr;
            control_pkg::op_eor: r_fn = control_pkg::fn_eor;
            control_pkg::op_lsl: begin
                r_fn    = control_pkg::fn_lsl;
                r_shift = 1'b1;
            end
            control_pkg::op_lsr: begin
                r_fn    = control_pkg::fn_lsr;
                r_shift = 1'b1;
            end
            default: begin
                r_valid = 1'b0;
                r_fn    = control_pkg::fn_add;
            end
        endcase
    end

    // Data instructions finish in one execute cycle
    always_comb begin
        control_word = '0;
        next_state   = control_pkg::st_fetch;
        constant     = '0;
        if (state == control_pkg::st_execute) begin
            if (op11 == control_pkg::op_ldur) begin
                control_word[control_pkg::da_lsb +: 5]         = rd;
                control_word[control_pkg::sa_lsb +: 5]         = rn;
                control_word[control_pkg::fs_lsb +: 5]         = control_pkg::fn_add;
                control_word[control_pkg::b_sel_bit]           = 1'b1;
                control_word[control_pkg::mem_read_bit]        = 1'b1;
                control_word[control_pkg::address_source_bit]  = 1'b1;
                control_word[control_pkg::c_sel_lsb +: 2]      = control_pkg::src_memory;
                control_word[control_pkg::reg_write_bit]       = 1'b1;
                constant = d_constant;
            end else if (op11 == control_pkg::op_stur) begin
                // Rt goes out on the B port as store data
                control_word[control_pkg::sa_lsb +: 5]         = rn;
                control_word[control_pkg::sb_lsb +: 5]         = rd;
                control_word[control_pkg::fs_lsb +: 5]         = control_pkg::fn_add;
                control_word[control_pkg::b_sel_bit]           = 1'b1;
                control_word[control_pkg::address_source_bit]  = 1'b1;
                control_word[control_pkg::mem_write_bit]       = 1'b1;
                constant = d_constant;
            end else if (i_valid) begin
                control_word[control_pkg::da_lsb +: 5]    = rd;
                control_word[control_pkg::sa_lsb +: 5]    = rn;
                control_word[control_pkg::fs_lsb +: 5]    = i_fn;
                control_word[control_pkg::b_sel_bit]      = 1'b1;
                control_word[control_pkg::reg_write_bit]  = 1'b1;
                control_word[control_pkg::c_sel_lsb +: 2] = control_pkg::src_alu;
                constant = i_constant;
            end else if (op9 == control_pkg::op_movz) begin
                control_word[control_pkg::da_lsb +: 5]    = rd;
                control_word[control_pkg::sa_lsb +: 5]    = rn;
                control_word[control_pkg::fs_lsb +: 5]    = control_pkg::fn_pass_b;
                control_word[control_pkg::b_sel_bit]      = 1'b1;
                control_word[control_pkg::reg_write_bit]  = 1'b1;
                control_word[control_pkg::c_sel_lsb +: 2] = control_pkg::src_alu;
                constant = movz_constant;
            end else if (r_valid) begin
                control_word[control_pkg::da_lsb +: 5]    = rd;
                control_word[control_pkg::sa_lsb +: 5]    = rn;
                control_word[control_pkg::sb_lsb +: 5]    = rm;
                control_word[control_pkg::fs_lsb +: 5]    = r_fn;
                control_word[control_pkg::b_sel_bit]      = r_shift;
                control_word[control_pkg::reg_write_bit]  = 1'b1;
                control_word[control_pkg::c_sel_lsb +: 2] = control_pkg::src_alu;
                constant = r_shift ? shift_constant : '0;
            end
        end
    end

endmodule

//--- condition_check.sv
`timescale 1ns/1ps

module condition_check (
    input  logic [3:0] condition,
    input  logic [3:0] flags,
    output logic       taken
);

    logic n;
    logic z;
    logic c;
    logic v;

    // Stored flags arrive as N, Z, C, V from the top bit down
    assign {n, z, c, v} = flags;

    always_comb begin
        case (condition)
            4'd0:  taken = z;
            4'd1:  taken = !z;
            4'd2:  taken = c;
            4'd3:  taken = !c;
            4'd4:  taken = n;
            4'd5:  taken = !n;
            4'd6:  taken = v;
            4'd7:  taken = !v;
            // Unsigned higher and lower or same
            4'd8:  taken = c && !z;
            4'd9:  taken = !(c && !z);
            // Signed compares
            4'd10: taken = (n == v);
            4'd11: taken = (n != v);
            4'd12: taken = !z && (n == v);
            4'd13: taken = !(!z && (n == v));
            // AL and NV both branch
            default: taken = 1'b1;
        endcase
    end

endmodule

//--- control_pkg.sv
package control_pkg;

    // Vector types with a fixed meaning
    typedef logic [31:0] instruction_t;
    typedef logic [4:0]  status_t;
    typedef logic [30:0] control_word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  alu_fn_t;

    // Multicycle sequencing
    typedef enum logic [1:0] {
        st_fetch     = 2'd0,
        st_execute   = 2'd1,
        st_execute_2 = 2'd2
    } state_t;

    // Control word field positions, lowest bit of each field
    localparam int da_lsb             = 26;
    localparam int sa_lsb             = 21;
    localparam int sb_lsb             = 16;
    localparam int fs_lsb             = 11;
    localparam int mem_write_bit      = 10;
    localparam int reg_write_bit      = 9;
    localparam int instr_load_bit     = 8;
    localparam int status_load_bit    = 7;
    localparam int b_sel_bit          = 6;
    localparam int c_sel_lsb          = 4;
    localparam int pc_sel_lsb         = 2;
    localparam int mem_read_bit       = 1;
    localparam int address_source_bit = 0;

    // ALU function codes
    localparam alu_fn_t fn_add    = 5'd0;
    localparam alu_fn_t fn_sub    = 5'd1;
    localparam alu_fn_t fn_and    = 5'd2;
    localparam alu_fn_t fn_orr    = 5'd3;
    localparam alu_fn_t fn_eor    = 5'd4;
    localparam alu_fn_t fn_lsl    = 5'd5;
    localparam alu_fn_t fn_lsr    = 5'd6;
    localparam alu_fn_t fn_pass_b = 5'd7;

    // Result source for the register write port
    localparam logic [1:0] src_alu    = 2'd0;
    localparam logic [1:0] src_memory = 2'd1;
    localparam logic [1:0] src_pc     = 2'd2;

    // PC update select
    localparam logic [1:0] pc_hold      = 2'd0;
    localparam logic [1:0] pc_increment = 2'd1;
    localparam logic [1:0] pc_relative  = 2'd2;
    localparam logic [1:0] pc_register  = 2'd3;

    // D format, bits 31 to 21
    localparam logic [10:0] op_ldur = 11'b11111000010;
    localparam logic [10:0] op_stur = 11'b11111000000;

    // I format, bits 31 to 22
    localparam logic [9:0] op_addi = 10'b1001000100;
    localparam logic [9:0] op_subi = 10'b1101000100;
    localparam logic [9:0] op_andi = 10'b1001001000;
    localparam logic [9:0] op_orri = 10'b1011001000;
    localparam logic [9:0] op_eori = 10'b1101001000;

    // IW format, bits 31 to 23
    localparam logic [8:0] op_movz = 9'b110100101;

    // R format, bits 31 to 21
    localparam logic [10:0] op_add = 11'b10001011000;
    localparam logic [10:0] op_sub = 11'b11001011000;
    localparam logic [10:0] op_and = 11'b10001010000;
    localparam logic [10:0] op_orr = 11'b10101010000;
    localparam logic [10:0] op_eor = 11'b11001010000;
    localparam logic [10:0] op_lsl = 11'b11010011011;
    localparam logic [10:0] op_lsr = 11'b11010011010;

    // Branch formats
    localparam logic [5:0]  op_b     = 6'b000101;
    localparam logic [5:0]  op_bl    = 6'b100101;
    localparam logic [7:0]  op_bcond = 8'b01010100;
    localparam logic [7:0]  op_cbz   = 8'b10110100;
    localparam logic [7:0]  op_cbnz  = 8'b10110101;
    localparam logic [10:0] op_br    = 11'b11010110000;

endpackage
